/* all.f */
hw/ubaBusPkg.sv
hw/ubaDevPkg.sv
hw/ubaStatusReg.sv
hw/ubaIntReqLatch.sv
hw/ubaIntr.sv
hw/ubaIntrTop.sv
testbench/tbClock.sv
testbench/ubaIntrTb.sv

/* hw/ubaBusPkg.sv */
// CPU-side types and status-register layout; level 0 means no interrupt, the 18-bit word is IO bus data
package ubaBusPkg;

   ////////////////////////////////////////////////////////////
   // Bus types
   ////////////////////////////////////////////////////////////

   // Priority interrupt level, 0 is no interrupt
   typedef logic [2:0] piLevelT;

   // PI request lines toward the CPU
   // Bit n-1 carries level n
   typedef logic [6:0] piReqT;

   // IO bus data word
   typedef logic [17:0] ioDataT;

   ////////////////////////////////////////////////////////////
   // Status register field positions
   ////////////////////////////////////////////////////////////

   // PIL assignment, bits 2..0
   localparam int csrPilLsb = 0;

   // PIH assignment, bits 5..3
   localparam int csrPihLsb = 3;

   // Read-only status bits
   // BR5 or BR4 pending
   localparam int csrIntLoBit = 10;

   // BR7 or BR6 pending
   localparam int csrIntHiBit = 11;

endpackage

/* hw/ubaDevPkg.sv */
// Device-side request lines and acknowledge codes; only BR7..BR4 exist, one code bit per line
package ubaDevPkg;

   ////////////////////////////////////////////////////////////
   // Device request lines
   ////////////////////////////////////////////////////////////

   // Bit 3 BR7, bit 2 BR6, bit 1 BR5, bit 0 BR4
   typedef logic [3:0] brLinesT;

   // Acknowledge code, same line order as requests
   typedef logic [3:0] ackCodeT;

   ////////////////////////////////////////////////////////////
   // Acknowledge codes
   ////////////////////////////////////////////////////////////

   // Nothing granted
   localparam ackCodeT ackNone = 4'b0000;

   // High group
   localparam ackCodeT ackBr7 = 4'b1000;
   localparam ackCodeT ackBr6 = 4'b0100;

   // Low group
   localparam ackCodeT ackBr5 = 4'b0010;
   localparam ackCodeT ackBr4 = 4'b0001;

endpackage

/* hw/ubaIntReqLatch.sv */
// Two devices only, device 1 nearest the adapter; an acknowledge for a level no device holds is dropped
`timescale 1ns/1ns

module ubaIntReqLatch
(
   input  logic              clk,
   input  logic              rst,
   input  ubaDevPkg::brLinesT dev1Br,
   input  ubaDevPkg::brLinesT dev2Br,
   input  ubaDevPkg::ackCodeT devIntA,
   output ubaDevPkg::brLinesT pendReq,
   output ubaDevPkg::ackCodeT dev1Ack,
   output ubaDevPkg::ackCodeT dev2Ack
);

   import ubaDevPkg::*;

   // Pending requests, one vector per device
   brLinesT dev1Pend;
   brLinesT dev2Pend;

   ////////////////////////////////////////////////////////////
   // Acknowledge chain
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      // Device 1 takes the grant if it holds that level
      dev1Ack = devIntA & dev1Pend;
      // Otherwise it passes down to device 2
      dev2Ack = devIntA & ~dev1Pend & dev2Pend;
   end

   ////////////////////////////////////////////////////////////
   // Request latches
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dev1Pend <= '0;
         dev2Pend <= '0;
      end
      else
      begin
         // Granted bit clears
         // A fresh pulse on the same edge sets it again
         dev1Pend <= (dev1Pend & ~dev1Ack) | dev1Br;
         dev2Pend <= (dev2Pend & ~dev2Ack) | dev2Br;
      end
   end

   // Merged view for the interrupt block
   assign pendReq = dev1Pend | dev2Pend;

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // Only one device per acknowledge
   assert property (@(posedge clk) disable iff (rst)
      !((dev1Ack != ackNone) && (dev2Ack != ackNone)))
      else $error("Both devices acknowledged in the same cycle");

   // Grant lands only on a line the device had pending
   assert property (@(posedge clk) disable iff (rst)
      ((dev1Ack & ~dev1Pend) == ackNone) && ((dev2Ack & ~dev2Pend) == ackNone))
      else $error("Acknowledge routed to a device without that request pending");

endmodule

/* hw/ubaIntr.sv */
// busPi is compared as given, so a read at level 0 matches an unassigned group; PIH wins a tie
`timescale 1ns/1ns

module ubaIntr
(
   input  logic               clk,
   input  logic               rst,
   input  ubaDevPkg::brLinesT  pendReq,
   input  ubaBusPkg::piLevelT  busPi,
   input  logic               wruRead,
   input  ubaBusPkg::piLevelT  statPih,
   input  ubaBusPkg::piLevelT  statPil,
   output logic               statIntHi,
   output logic               statIntLo,
   output ubaBusPkg::piReqT    busIntr,
   output ubaDevPkg::ackCodeT  devIntA
);

   import ubaBusPkg::*;
   import ubaDevPkg::*;

   ////////////////////////////////////////////////////////////
   // Request groups
   ////////////////////////////////////////////////////////////

   // High group is BR7/BR6, low group BR5/BR4
   assign statIntHi = |(pendReq & (ackBr7 | ackBr6));
   assign statIntLo = |(pendReq & (ackBr5 | ackBr4));

   // Level to PI line, bit n-1 for level n
   function automatic piReqT levelOneHot(input piLevelT lvl);
      piReqT lines;
      lines = '0;
      // Level 0 raises nothing
      if (lvl != '0)
         lines[lvl - 1'b1] = 1'b1;
      return lines;
   endfunction

   ////////////////////////////////////////////////////////////
   // PI request to CPU
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      busIntr = '0;
      if (statIntHi)
         busIntr = busIntr | levelOneHot(statPih);
      // Same level for both groups just merges
      if (statIntLo)
         busIntr = busIntr | levelOneHot(statPil);
   end

   ////////////////////////////////////////////////////////////
   // Who-are-you acknowledge
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         devIntA <= ackNone;
      else if (wruRead && (busPi == statPih))
      begin
         // BR7 before BR6
         if ((pendReq & ackBr7) != ackNone)
            devIntA <= ackBr7;
         else if ((pendReq & ackBr6) != ackNone)
            devIntA <= ackBr6;
         else
            devIntA <= ackNone;
      end
      else if (wruRead && (busPi == statPil))
      begin
         // BR5 before BR4
         if ((pendReq & ackBr5) != ackNone)
            devIntA <= ackBr5;
         else if ((pendReq & ackBr4) != ackNone)
            devIntA <= ackBr4;
         else
            devIntA <= ackNone;
      end
      else
         devIntA <= ackNone;
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // At most one line granted
   assert property (@(posedge clk) disable iff (rst)
      $onehot0(devIntA))
      else $error("Acknowledge code has more than one line set");

   // Grant only follows a read
   assert property (@(posedge clk) disable iff (rst)
      (devIntA != ackNone) |-> $past(wruRead))
      else $error("Acknowledge seen without a preceding who-are-you read");

endmodule

/* hw/ubaIntrTop.sv */
// Interrupt path only; no vector fetch, no paging RAM, no other status-register bits
`timescale 1ns/1ns

module ubaIntrTop
(
   input  logic               clk,
   input  logic               rst,
   input  logic               regWrite,
   input  ubaBusPkg::ioDataT   regWriteData,
   output ubaBusPkg::ioDataT   regReadData,
   input  ubaDevPkg::brLinesT  dev1Br,
   input  ubaDevPkg::brLinesT  dev2Br,
   output ubaDevPkg::ackCodeT  dev1Ack,
   output ubaDevPkg::ackCodeT  dev2Ack,
   input  ubaBusPkg::piLevelT  busPi,
   input  logic               wruRead,
   output ubaBusPkg::piReqT    busIntr,
   output ubaDevPkg::ackCodeT  devIntA
);

   import ubaBusPkg::*;
   import ubaDevPkg::*;

   // Register to interrupt block
   piLevelT statPih;
   piLevelT statPil;
   // Interrupt block status back to register
   logic    statIntHi;
   logic    statIntLo;
   // Merged device requests
   brLinesT pendReq;

   // PI assignments
   ubaStatusReg statReg_i (.clk(clk), .rst(rst), .regWrite(regWrite),
      .regWriteData(regWriteData), .statIntHi(statIntHi), .statIntLo(statIntLo),
      .statPih(statPih), .statPil(statPil), .regReadData(regReadData));

   // Device requests and acknowledge chain
   ubaIntReqLatch reqLatch_i (.clk(clk), .rst(rst), .dev1Br(dev1Br), .dev2Br(dev2Br),
      .devIntA(devIntA), .pendReq(pendReq), .dev1Ack(dev1Ack), .dev2Ack(dev2Ack));

   // PI encoding and acknowledge
   ubaIntr intr_i (.clk(clk), .rst(rst), .pendReq(pendReq), .busPi(busPi),
      .wruRead(wruRead), .statPih(statPih), .statPil(statPil),
      .statIntHi(statIntHi), .statIntLo(statIntLo), .busIntr(busIntr),
      .devIntA(devIntA));

endmodule

/* hw/ubaStatusReg.sv */
// Holds only PIH and PIL; INTHI and INTLO are live inputs, all other readback bits are zero
`timescale 1ns/1ns

module ubaStatusReg
(
   input  logic               clk,
   input  logic               rst,
   input  logic               regWrite,
   input  ubaBusPkg::ioDataT  regWriteData,
   input  logic               statIntHi,
   input  logic               statIntLo,
   output ubaBusPkg::piLevelT statPih,
   output ubaBusPkg::piLevelT statPil,
   output ubaBusPkg::ioDataT  regReadData
);

   import ubaBusPkg::*;

   ////////////////////////////////////////////////////////////
   // PI assignment register
   ////////////////////////////////////////////////////////////

   // Width of one PI field
   localparam int piWidth = $bits(piLevelT);

   // Both assignments load together on the write strobe
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         statPih <= '0;
         statPil <= '0;
      end
      else if (regWrite)
      begin
         // Pick fields out of the bus word
         statPih <= regWriteData[csrPihLsb +: piWidth];
         statPil <= regWriteData[csrPilLsb +: piWidth];
      end
   end

   ////////////////////////////////////////////////////////////
   // Readback
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      // Unused bits read as zero
      regReadData = '0;
      regReadData[csrPihLsb +: piWidth] = statPih;
      regReadData[csrPilLsb +: piWidth] = statPil;
      // Live request status from the interrupt block
      regReadData[csrIntHiBit] = statIntHi;
      regReadData[csrIntLoBit] = statIntLo;
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // Nothing leaks outside the four defined fields
   assert property (@(posedge clk) disable iff (rst)
      (regReadData & ~((ioDataT'({piWidth{1'b1}}) << csrPihLsb)
                     | (ioDataT'({piWidth{1'b1}}) << csrPilLsb)
                     | (ioDataT'(1) << csrIntHiBit)
                     | (ioDataT'(1) << csrIntLoBit))) == '0)
      else $error("Status readback has bits set outside its fields");

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the interrupt path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=ubaIntrSim

verilator --binary --timing --assert -j 0 \
   --top-module ubaIntrTb -f all.f -o "$SIM"
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
   echo "Simulation reported failure"
   exit 1
fi

echo "Simulation passed"
exit 0

/* testbench/tbClock.sv */
// Free-running 100 ns clock; reset starts high and drops 10 ns after the third rising edge
`timescale 1ns/1ns

module tbClock
(
   output logic clk,
   output logic rst
);

   // Half of the 100 ns period
   localparam int halfPeriod = 50;

   // Reset held for three cycles
   initial
   begin
      clk = 1'b0;
      rst = 1'b1;
      repeat (3) @(posedge clk);
      #10 rst = 1'b0;
   end

   always
   begin
      #halfPeriod clk = ~clk;
   end

endmodule

/* testbench/ubaIntrTb.sv */
// Self-checking run of the interrupt path; the reference model assumes at most one grant per read
`timescale 1ns/1ns

module ubaIntrTb;

   import ubaBusPkg::*;
   import ubaDevPkg::*;

   // Run length, used by the watchdog
   localparam int directedCycles = 100;
   localparam int randomCycles   = 400;
   localparam int marginCycles   = 50;
   localparam int watchdogNs     = (3 + directedCycles + randomCycles + marginCycles) * 100;
   // Inputs change this long after the rising edge
   localparam int driveDelay     = 10;

   logic    clk;
   logic    rst;
   logic    regWrite;
   ioDataT  regWriteData;
   ioDataT  regReadData;
   brLinesT dev1Br;
   brLinesT dev2Br;
   ackCodeT dev1Ack;
   ackCodeT dev2Ack;
   piLevelT busPi;
   logic    wruRead;
   piReqT   busIntr;
   ackCodeT devIntA;

   int      errors = 0;
   // Proof that the chain and the merge case were reached
   int      dev2Grants = 0;
   int      mergedSeen = 0;

   tbClock clock_i (.clk(clk), .rst(rst));

   ubaIntrTop dut_i (.clk(clk), .rst(rst), .regWrite(regWrite),
      .regWriteData(regWriteData), .regReadData(regReadData), .dev1Br(dev1Br),
      .dev2Br(dev2Br), .dev1Ack(dev1Ack), .dev2Ack(dev2Ack), .busPi(busPi),
      .wruRead(wruRead), .busIntr(busIntr), .devIntA(devIntA));

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   piLevelT mPih;
   piLevelT mPil;
   brLinesT m1Pend;
   brLinesT m2Pend;
   ackCodeT mIntA;
   logic    expHi;
   logic    expLo;
   piReqT   expBusIntr;
   ackCodeT expDev1Ack;
   ackCodeT expDev2Ack;
   ioDataT  expRead;

   // Who-are-you answer, high group checked first
   function automatic ackCodeT expectedAck(input logic rd, input piLevelT lvl,
      input piLevelT pih, input piLevelT pil, input brLinesT pend);
      ackCodeT code;
      code = ackNone;
      if (rd && (lvl == pih))
      begin
         if (pend[3])
            code = ackBr7;
         else if (pend[2])
            code = ackBr6;
      end
      else if (rd && (lvl == pil))
      begin
         if (pend[1])
            code = ackBr5;
         else if (pend[0])
            code = ackBr4;
      end
      return code;
   endfunction

   always_comb
   begin
      expHi = m1Pend[3] | m1Pend[2] | m2Pend[3] | m2Pend[2];
      expLo = m1Pend[1] | m1Pend[0] | m2Pend[1] | m2Pend[0];
      // One PI line per active group, none at level 0
      expBusIntr = '0;
      if (expHi && (mPih != 3'd0))
         expBusIntr[mPih - 3'd1] = 1'b1;
      if (expLo && (mPil != 3'd0))
         expBusIntr[mPil - 3'd1] = 1'b1;
      // Device 1 first in the chain
      expDev1Ack = ackNone;
      expDev2Ack = ackNone;
      if (mIntA != ackNone)
      begin
         if ((m1Pend & mIntA) != ackNone)
            expDev1Ack = mIntA;
         else if ((m2Pend & mIntA) != ackNone)
            expDev2Ack = mIntA;
      end
      expRead = '0;
      expRead[csrPihLsb +: 3] = mPih;
      expRead[csrPilLsb +: 3] = mPil;
      expRead[csrIntHiBit] = expHi;
      expRead[csrIntLoBit] = expLo;
   end

   always @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         mPih   <= 3'd0;
         mPil   <= 3'd0;
         m1Pend <= '0;
         m2Pend <= '0;
         mIntA  <= ackNone;
      end
      else
      begin
         if (regWrite)
         begin
            mPih <= regWriteData[csrPihLsb +: 3];
            mPil <= regWriteData[csrPilLsb +: 3];
         end
         // Served bit clears, a new pulse sets it again
         m1Pend <= (m1Pend & ~expDev1Ack) | dev1Br;
         m2Pend <= (m2Pend & ~expDev2Ack) | dev2Br;
         mIntA  <= expectedAck(wruRead, busPi, mPih, mPil, m1Pend | m2Pend);
         if (expDev2Ack != ackNone)
            dev2Grants <= dev2Grants + 1;
         if (expHi && expLo && (mPih == mPil) && (mPih != 3'd0))
            mergedSeen <= mergedSeen + 1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   task automatic reportMismatch(input string name, input logic [31:0] expVal,
      input logic [31:0] actVal);
      $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
      errors++;
   endtask

   assert property (@(posedge clk) disable iff (rst) busIntr === expBusIntr)
      else reportMismatch("busIntr", 32'($sampled(expBusIntr)), 32'($sampled(busIntr)));

   assert property (@(posedge clk) disable iff (rst) devIntA === mIntA)
      else reportMismatch("devIntA", 32'($sampled(mIntA)), 32'($sampled(devIntA)));

   assert property (@(posedge clk) disable iff (rst) dev1Ack === expDev1Ack)
      else reportMismatch("dev1Ack", 32'($sampled(expDev1Ack)), 32'($sampled(dev1Ack)));

   assert property (@(posedge clk) disable iff (rst) dev2Ack === expDev2Ack)
      else reportMismatch("dev2Ack", 32'($sampled(expDev2Ack)), 32'($sampled(dev2Ack)));

   assert property (@(posedge clk) disable iff (rst) regReadData === expRead)
      else reportMismatch("regReadData", 32'($sampled(expRead)), 32'($sampled(regReadData)));

   ////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////

   task automatic nextCycle();
      @(posedge clk);
      #driveDelay;
   endtask

   // Junk in the unused bits must not leak into readback
   task automatic writeCsr(input piLevelT pih, input piLevelT pil);
      regWriteData = 18'($urandom);
      regWriteData[csrPihLsb +: 3] = pih;
      regWriteData[csrPilLsb +: 3] = pil;
      regWrite = 1'b1;
      nextCycle();
      regWrite = 1'b0;
      nextCycle();
   endtask

   task automatic pulseReq(input brLinesT d1, input brLinesT d2);
      dev1Br = d1;
      dev2Br = d2;
      nextCycle();
      dev1Br = '0;
      dev2Br = '0;
      nextCycle();
   endtask

   // Read, then wait for the grant and the clear
   task automatic whoAreYou(input piLevelT lvl);
      wruRead = 1'b1;
      busPi = lvl;
      nextCycle();
      wruRead = 1'b0;
      nextCycle();
      nextCycle();
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      void'($urandom(9932));
      regWrite = 1'b0;
      regWriteData = '0;
      dev1Br = '0;
      dev2Br = '0;
      busPi = 3'd0;
      wruRead = 1'b0;
      @(negedge rst);
      // Quiet after reset
      repeat (3) nextCycle();
      // Level 0 assigned, requests raise nothing
      writeCsr(3'd0, 3'd0);
      pulseReq(4'b1001, 4'b0000);
      repeat (2) nextCycle();
      // Assign levels, pending requests now show
      writeCsr(3'd6, 3'd3);
      whoAreYou(3'd6);
      whoAreYou(3'd3);
      // Priority inside each group
      pulseReq(4'b0100, 4'b1000);
      pulseReq(4'b0001, 4'b0010);
      whoAreYou(3'd6);
      whoAreYou(3'd6);
      whoAreYou(3'd3);
      whoAreYou(3'd1);
      whoAreYou(3'd3);
      whoAreYou(3'd3);
      // Same level for both groups
      writeCsr(3'd4, 3'd4);
      pulseReq(4'b0110, 4'b0000);
      whoAreYou(3'd4);
      whoAreYou(3'd4);
      // Both devices at one level
      writeCsr(3'd7, 3'd2);
      pulseReq(4'b0010, 4'b0010);
      whoAreYou(3'd2);
      whoAreYou(3'd2);
      repeat (2) nextCycle();
      // Random mix
      for (int i = 0; i < randomCycles; i++)
      begin
         dev1Br = (($urandom % 8) == 0) ? 4'($urandom) : 4'b0000;
         dev2Br = (($urandom % 8) == 0) ? 4'($urandom) : 4'b0000;
         regWrite = (($urandom % 16) == 0);
         regWriteData = 18'($urandom);
         // Force equal levels half the time
         if (($urandom % 2) == 0)
            regWriteData[csrPilLsb +: 3] = regWriteData[csrPihLsb +: 3];
         wruRead = (($urandom % 3) == 0);
         case ($urandom % 3)
            0: busPi = mPih;
            1: busPi = mPil;
            default: busPi = 3'($urandom);
         endcase
         nextCycle();
      end
      dev1Br = '0;
      dev2Br = '0;
      regWrite = 1'b0;
      wruRead = 1'b0;
      repeat (4) nextCycle();
      if (dev2Grants == 0)
      begin
         $display("Device 2 never received an acknowledge, chain not exercised");
         errors++;
      end
      if (mergedSeen == 0)
      begin
         $display("Both groups never shared one PI level, merge not exercised");
         errors++;
      end
      $display("Run complete with %0d errors", errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   // Watchdog
   initial
   begin
      #watchdogNs;
      $display("Watchdog expired, simulation did not finish in time");
      $display("Test FAILED");
      $finish;
   end

endmodule
